// ==== src.f ====
logic/lsu_pkg.sv
logic/load_extend.sv
logic/lsu_unit.sv
logic/axil_data_mem.sv
logic/lsu_top.sv
test/lsu_tb.sv

// ==== test/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

  localparam int N_DIRECTED = 34;
  localparam int N_RANDOM = 400;
  localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 64 + 100;
  localparam int MEM_BYTES = lsu_pkg::MEM_WORDS * 4;

  logic               clk;
  logic               rst_n_i;
  logic               req_valid_i;
  logic               req_ready_o;
  lsu_pkg::lsu_req_t  req_i;
  logic               resp_valid_o;
  lsu_pkg::lsu_resp_t resp_o;

  logic [7:0] ref_mem [MEM_BYTES]; // byte-wide copy of the data memory.
  integer     seed;
  int         error_count;
  int         req_count;

  lsu_top dut_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %h got %h", $time, what, expected, actual);
      error_count++;
    end
  endtask

  // expected response of one request, applied to the byte array.
  task automatic apply_model(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, output lsu_pkg::lsu_resp_t resp);
    logic [7:0] b0;
    logic [7:0] b1;
    resp = '0;
    if (addr >= MEM_BYTES) begin
      resp.err = 1'b1; // nothing read or written.
    end else begin
      b0 = ref_mem[addr];
      b1 = ref_mem[addr | 32'd1];
      case (op)
        lsu_pkg::LB:  resp.rdata = {{24{b0[7]}}, b0};
        lsu_pkg::LBU: resp.rdata = {24'd0, b0};
        lsu_pkg::LH:  resp.rdata = {{16{b1[7]}}, b1, b0};
        lsu_pkg::LHU: resp.rdata = {16'd0, b1, b0};
        lsu_pkg::LW:  resp.rdata = {ref_mem[addr + 3], ref_mem[addr + 2], b1, b0};
        lsu_pkg::SB:  ref_mem[addr] = wdata[7:0];
        lsu_pkg::SH: begin
          ref_mem[addr]     = wdata[7:0];
          ref_mem[addr + 1] = wdata[15:8];
        end
        default: begin
          for (int i = 0; i < 4; i++) begin
            ref_mem[addr + i] = wdata[8*i +: 8];
          end
        end
      endcase
    end
  endtask

  // entered and left 1 ns after a rising edge; outputs sampled at the falling edge.
  task automatic run_request(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
    lsu_pkg::lsu_resp_t exp_resp;
    bit                 accepted;
    bit                 answered;
    accepted    = 1'b0;
    answered    = 1'b0;
    req_i.op    = op;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    req_valid_i = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      check_value($sformatf("req %0d extra response pulse", req_count), 32'd0, resp_valid_o);
      accepted = req_ready_o;
      @(posedge clk);
      #1;
    end
    apply_model(op, addr, wdata, exp_resp);
    req_valid_i = 1'b0;
    req_i = '0;
    while (!answered) begin
      @(negedge clk);
      if (resp_valid_o) begin
        answered = 1'b1;
        check_value($sformatf("req %0d %s @%h rdata", req_count, op.name(), addr),
                    exp_resp.rdata, resp_o.rdata);
        check_value($sformatf("req %0d %s @%h err", req_count, op.name(), addr),
                    {31'd0, exp_resp.err}, {31'd0, resp_o.err});
      end else begin
        check_value($sformatf("req %0d ready while busy", req_count), 32'd0, req_ready_o);
      end
      @(posedge clk);
      #1;
    end
    req_count++;
  endtask

  task automatic random_request();
    logic [31:0]      r;
    logic [31:0]      addr;
    lsu_pkg::mem_op_e op;
    r  = $random(seed);
    op = lsu_pkg::mem_op_e'({1'b0, r[2:0]});
    if (r[7:4] == 4'd0) begin
      addr = $random(seed);
      addr[12] = 1'b1; // beyond the memory.
    end else begin
      addr = $random(seed) & (r[20] ? 32'hfff : 32'h7f); // mostly a small window.
    end
    if (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) addr[0] = 1'b0;
    if (op inside {lsu_pkg::LW, lsu_pkg::SW}) addr[1:0] = 2'b00;
    run_request(op, addr, $random(seed));
  endtask

  initial begin
    seed        = 32'h82c7_6a69;
    error_count = 0;
    req_count   = 0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    check_value("ready after reset", 32'd1, req_ready_o);
    check_value("response after reset", 32'd0, resp_valid_o);
    @(posedge clk);
    #1;

    // strobes and lanes, each store read back as a word.
    run_request(lsu_pkg::SW, 32'h40, 32'h1122_3344);
    run_request(lsu_pkg::LW, 32'h40, 32'h0);
    for (int off = 0; off < 4; off++) begin
      run_request(lsu_pkg::SB, 32'h40 + off, $random(seed));
      run_request(lsu_pkg::LW, 32'h40, 32'h0);
    end
    for (int off = 0; off < 4; off += 2) begin
      run_request(lsu_pkg::SH, 32'h40 + off, $random(seed));
      run_request(lsu_pkg::LW, 32'h40, 32'h0);
    end

    // sub-word loads over bytes with mixed sign bits.
    run_request(lsu_pkg::SW, 32'h80, 32'h80f1_7f0e);
    for (int off = 0; off < 4; off++) begin
      run_request(lsu_pkg::LB, 32'h80 + off, 32'h0);
      run_request(lsu_pkg::LBU, 32'h80 + off, 32'h0);
    end
    for (int off = 0; off < 4; off += 2) begin
      run_request(lsu_pkg::LH, 32'h80 + off, 32'h0);
      run_request(lsu_pkg::LHU, 32'h80 + off, 32'h0);
    end
    run_request(lsu_pkg::LW, 32'h80, 32'h0);

    // out of range, memory must stay untouched.
    run_request(lsu_pkg::SW, 32'h1000, 32'hffff_ffff);
    run_request(lsu_pkg::LW, 32'h1000, 32'h0);
    run_request(lsu_pkg::SB, 32'h8000_0041, 32'h0000_00a5);
    run_request(lsu_pkg::LHU, 32'hffff_fffe, 32'h0);
    run_request(lsu_pkg::LW, 32'h40, 32'h0);
    run_request(lsu_pkg::LW, 32'h0, 32'h0);

    for (int n = 0; n < N_RANDOM; n++) begin
      random_request();
    end

    @(negedge clk);
    check_value("response after last request", 32'd0, resp_valid_o);
    $display("%0d errors in %0d requests", error_count, req_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  lsu_pkg::lsu_req_t  req_i,
  output logic               resp_valid_o,
  output lsu_pkg::lsu_resp_t resp_o
);

  logic                ar_valid, ar_ready;
  logic                aw_valid, aw_ready;
  logic                w_valid, w_ready;
  logic                r_valid, r_ready;
  logic                b_valid, b_ready;
  lsu_pkg::axil_addr_t ar, aw;
  lsu_pkg::axil_w_t    w;
  lsu_pkg::axil_r_t    r;
  lsu_pkg::axil_b_t    b;

  lsu_unit lsu_unit_i (
    .clk, .rst_n_i,
    .req_valid_i, .req_ready_o, .req_i,
    .resp_valid_o, .resp_o,
    .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_o (ar),
    .aw_valid_o (aw_valid), .aw_ready_i (aw_ready), .aw_o (aw),
    .w_valid_o  (w_valid),  .w_ready_i  (w_ready),  .w_o  (w),
    .r_valid_i  (r_valid),  .r_ready_o  (r_ready),  .r_i  (r),
    .b_valid_i  (b_valid),  .b_ready_o  (b_ready),  .b_i  (b)
  );

  axil_data_mem axil_data_mem_i (
    .clk, .rst_n_i,
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_i (ar),
    .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_i (aw),
    .w_valid_i  (w_valid),  .w_ready_o  (w_ready),  .w_i  (w),
    .r_valid_o  (r_valid),  .r_ready_i  (r_ready),  .r_o  (r),
    .b_valid_o  (b_valid),  .b_ready_i  (b_ready),  .b_o  (b)
  );

endmodule

// ==== logic/axil_data_mem.sv ====
`timescale 1ns/1ps

module axil_data_mem (
  input  logic                 clk,
  input  logic                 rst_n_i,
  // read address
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  lsu_pkg::axil_addr_t  ar_i,
  // write address
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  lsu_pkg::axil_addr_t  aw_i,
  // write data
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  lsu_pkg::axil_w_t     w_i,
  // read data
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output lsu_pkg::axil_r_t     r_o,
  // write response
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  output lsu_pkg::axil_b_t     b_o
);

  logic [lsu_pkg::DATA_W-1:0]    mem_q [lsu_pkg::MEM_WORDS];
  logic [19:0]                   lfsr_q;
  logic                          aw_got_q;
  logic                          w_got_q;
  logic                          r_valid_q;
  logic                          b_valid_q;
  lsu_pkg::axil_addr_t           aw_q;
  lsu_pkg::axil_w_t              w_q;
  lsu_pkg::axil_r_t              r_q;
  lsu_pkg::axil_b_t              b_q;
  logic                          ar_hs;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          wr_fire;
  logic                          wr_ok;
  logic                          rd_ok;
  lsu_pkg::axil_addr_t           wr_addr;
  lsu_pkg::axil_w_t              wr_data;
  logic [lsu_pkg::MEM_IDX_W-1:0] wr_idx;
  logic [lsu_pkg::MEM_IDX_W-1:0] rd_idx;

  // contents start cleared.
  initial begin
    for (int i = 0; i < lsu_pkg::MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // every ready waits for a set top bit.
  assign ar_ready_o = lfsr_q[19] & ~r_valid_q;
  assign aw_ready_o = lfsr_q[19] & ~aw_got_q & ~b_valid_q;
  assign w_ready_o = lfsr_q[19] & ~w_got_q & ~b_valid_q;

  assign ar_hs = ar_valid_i & ar_ready_o;
  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs = w_valid_i & w_ready_o;

  // a half that arrived earlier is taken from its capture register.
  assign wr_addr = aw_got_q ? aw_q : aw_i;
  assign wr_data = w_got_q ? w_q : w_i;
  assign wr_fire = (aw_got_q | aw_hs) & (w_got_q | w_hs);

  assign wr_ok = wr_addr.addr[lsu_pkg::ADDR_W-1:2] < lsu_pkg::MEM_WORDS;
  assign rd_ok = ar_i.addr[lsu_pkg::ADDR_W-1:2] < lsu_pkg::MEM_WORDS;
  assign wr_idx = wr_addr.addr[2 +: lsu_pkg::MEM_IDX_W];
  assign rd_idx = ar_i.addr[2 +: lsu_pkg::MEM_IDX_W];

  assign r_valid_o = r_valid_q;
  assign b_valid_o = b_valid_q;
  assign r_o = r_q;
  assign b_o = b_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lfsr_q    <= lsu_pkg::LFSR_SEED;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]}; // x^20 + x^17 + 1.
      if (ar_hs) r_valid_q <= 1'b1;
      else if (r_ready_i) r_valid_q <= 1'b0;
      if (wr_fire) begin
        aw_got_q  <= 1'b0;
        w_got_q   <= 1'b0;
        b_valid_q <= 1'b1;
      end else begin
        if (aw_hs) aw_got_q <= 1'b1;
        if (w_hs) w_got_q <= 1'b1;
        if (b_ready_i) b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) aw_q <= aw_i;
    if (w_hs) w_q <= w_i;
    if (ar_hs) begin
      r_q.data <= rd_ok ? mem_q[rd_idx] : '0;
      r_q.resp <= rd_ok ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
    end
    if (wr_fire) begin
      b_q.resp <= wr_ok ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < lsu_pkg::STRB_W; i++) begin
      if (wr_fire && wr_ok && wr_data.strb[i]) begin
        mem_q[wr_idx][8*i +: 8] <= wr_data.data[8*i +: 8];
      end
    end
  end

endmodule

// ==== logic/lsu_unit.sv ====
`timescale 1ns/1ps

module lsu_unit (
  input  logic                 clk,
  input  logic                 rst_n_i,
  // core side
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_pkg::lsu_req_t    req_i,
  output logic                 resp_valid_o,
  output lsu_pkg::lsu_resp_t   resp_o,
  // read address
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output lsu_pkg::axil_addr_t  ar_o,
  // write address
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  output lsu_pkg::axil_addr_t  aw_o,
  // write data
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  output lsu_pkg::axil_w_t     w_o,
  // read data
  input  logic                 r_valid_i,
  output logic                 r_ready_o,
  input  lsu_pkg::axil_r_t     r_i,
  // write response
  input  logic                 b_valid_i,
  output logic                 b_ready_o,
  input  lsu_pkg::axil_b_t     b_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE,
    ST_RESP
  } state_e;

  state_e                        state_q;
  lsu_pkg::lsu_req_t             req_q;
  lsu_pkg::lsu_resp_t            resp_q;
  logic                          ar_pend_q;
  logic                          aw_pend_q;
  logic                          w_pend_q;
  logic                          req_hs;
  logic                          req_is_load;
  logic                          ar_hs;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          r_hs;
  logic                          b_hs;
  logic [1:0]                    byte_off;
  logic [lsu_pkg::STRB_W-1:0]    strb_base;
  logic [lsu_pkg::DATA_W-1:0]    load_data;

  // the respond cycle also takes the next request.
  assign req_ready_o = (state_q == ST_IDLE) || (state_q == ST_RESP);
  assign req_hs = req_valid_i & req_ready_o;
  assign req_is_load = req_i.op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW,
                                        lsu_pkg::LBU, lsu_pkg::LHU};

  assign ar_hs = ar_valid_o & ar_ready_i;
  assign aw_hs = aw_valid_o & aw_ready_i;
  assign w_hs = w_valid_o & w_ready_i;
  assign r_hs = r_valid_i & r_ready_o;
  assign b_hs = b_valid_i & b_ready_o;

  assign byte_off = req_q.addr[1:0];

  always_comb begin
    case (req_q.op)
      lsu_pkg::SB: strb_base = 4'b0001;
      lsu_pkg::SH: strb_base = 4'b0011;
      default:     strb_base = 4'b1111;
    endcase
  end

  // bus payloads come straight from the latched request.
  assign ar_o.addr = {req_q.addr[lsu_pkg::ADDR_W-1:2], 2'b00};
  assign aw_o.addr = {req_q.addr[lsu_pkg::ADDR_W-1:2], 2'b00};
  assign w_o.data = req_q.wdata << {byte_off, 3'b000}; // move into its lanes.
  assign w_o.strb = strb_base << byte_off;

  assign ar_valid_o = ar_pend_q;
  assign aw_valid_o = aw_pend_q;
  assign w_valid_o = w_pend_q;
  assign r_ready_o = (state_q == ST_READ);
  assign b_ready_o = (state_q == ST_WRITE);

  assign resp_valid_o = (state_q == ST_RESP);
  assign resp_o = resp_q;

  load_extend load_extend_i (
    .op_i       (req_q.op),
    .byte_off_i (byte_off),
    .word_i     (r_i.data),
    .data_o     (load_data)
  );

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      ar_pend_q <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE, ST_RESP: begin
          state_q <= ST_IDLE;
          if (req_hs && req_is_load) begin
            state_q   <= ST_READ;
            ar_pend_q <= 1'b1;
          end else if (req_hs) begin
            state_q   <= ST_WRITE;
            aw_pend_q <= 1'b1; // aw and w go up together.
            w_pend_q  <= 1'b1;
          end
        end
        ST_READ: begin
          if (ar_hs) ar_pend_q <= 1'b0;
          if (r_hs) state_q <= ST_RESP;
        end
        ST_WRITE: begin
          if (aw_hs) aw_pend_q <= 1'b0;
          if (w_hs) w_pend_q <= 1'b0;
          if (b_hs) state_q <= ST_RESP; // b only follows both.
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_hs) req_q <= req_i;
    if (r_hs) begin
      resp_q.rdata <= load_data;
      resp_q.err   <= (r_i.resp == lsu_pkg::RESP_SLVERR);
    end else if (b_hs) begin
      resp_q.rdata <= '0; // stores return zero.
      resp_q.err   <= (b_i.resp == lsu_pkg::RESP_SLVERR);
    end
  end

endmodule

// ==== logic/load_extend.sv ====
`timescale 1ns/1ps

module load_extend (
  input  lsu_pkg::mem_op_e           op_i,
  input  logic [1:0]                 byte_off_i,
  input  logic [lsu_pkg::DATA_W-1:0] word_i,
  output logic [lsu_pkg::DATA_W-1:0] data_o
);

  logic [lsu_pkg::DATA_W-1:0] shifted;

  // bring the addressed lane down to bit 0.
  assign shifted = word_i >> {byte_off_i, 3'b000};

  always_comb begin
    case (op_i)
      lsu_pkg::LB: begin
        data_o = {{24{shifted[7]}}, shifted[7:0]}; // sign extend.
      end
      lsu_pkg::LBU: begin
        data_o = {24'd0, shifted[7:0]};
      end
      lsu_pkg::LH: begin
        data_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::LHU: begin
        data_o = {16'd0, shifted[15:0]};
      end
      default: begin
        data_o = shifted; // lw, offset is zero.
      end
    endcase
  end

endmodule

// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  localparam int MEM_WORDS = 1024;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS); // word index bits.

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // top bit clear, so no ready is offered straight out of reset.
  localparam logic [19:0] LFSR_SEED = 20'h5a5c3;

  typedef enum logic [3:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } mem_op_e;

  // one request from the execute stage.
  typedef struct packed {
    mem_op_e op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata; // extended load data.
    logic err;
  } lsu_resp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axil_addr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0] resp;
  } axil_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

endpackage
